// File: straddle_pkg.sv
`default_nettype none

package straddle_pkg;

    // Bus widths
    localparam int DATA_W      = 512;
    localparam int LANE_W      = 256;
    localparam int KEEP_W      = 16;
    localparam int LANE_KEEP_W = KEEP_W / 2;
    localparam int USER_W      = 161;

    // Sideband field positions for start and end markers and their pointers
    localparam int SOP_LSB     = 64;
    localparam int SOP_PTR_LSB = 68;
    localparam int EOP_LSB     = 76;
    localparam int EOP_PTR_LSB = 80;

    // Beat buffer per slot
    localparam int FIFO_DEPTH   = 16;
    localparam int FIFO_AW      = $clog2(FIFO_DEPTH);
    localparam int READY_MARGIN = 4;

    // Start-order queue, sized for every packet both slot FIFOs can hold
    localparam int ORDER_DEPTH = 4 * FIFO_DEPTH;
    localparam int ORDER_AW    = $clog2(ORDER_DEPTH);

    typedef enum logic [1:0] {
        LANE_FREE  = 2'd0,
        LANE_SLOT0 = 2'd1,
        LANE_SLOT1 = 2'd2
    } lane_owner_e;

    // Work for one slot out of one accepted input beat
    typedef struct packed {
        logic [1:0]             lane_mask;
        logic [LANE_W-1:0]      data_lo;
        logic [LANE_W-1:0]      data_hi;
        logic [LANE_KEEP_W-1:0] keep_lo;
        logic [LANE_KEEP_W-1:0] keep_hi;
        logic                   end_flag;
    } lane_cmd_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [KEEP_W-1:0] keep;
        logic              last;
    } beat_t;

    typedef struct packed {
        logic illegal_sop;
        logic illegal_eop;
    } err_flags_t;

endpackage

`default_nettype wire

// File: straddle_lane_decoder.sv
`default_nettype none

module straddle_lane_decoder import straddle_pkg::*; (
    input  wire               ACLK,
    input  wire               ARESETN,
    input  wire [USER_W-1:0]  s_tuser,
    input  wire [DATA_W-1:0]  s_tdata,
    input  wire [KEEP_W-1:0]  s_tkeep,
    input  wire               s_tvalid,
    input  wire               accept,
    output lane_cmd_t         cmd0,
    output lane_cmd_t         cmd1,
    output logic              cmd_valid,
    output logic              start_push,
    output logic              start_slot,
    output err_flags_t        err
);

    logic [1:0]        sop;
    logic [1:0]        sop_ptr0;
    logic [1:0]        eop;
    logic [3:0]        eop_ptr0;
    logic [3:0]        eop_ptr1;
    logic [1:0]        start_at;
    logic [1:0]        end_at;
    logic [2:0]        end_ptr [2];
    logic              fire;

    // Owner that continues into the next beat, and slot of the newest packet
    lane_owner_e       carry_q;
    logic              last_slot_q;

    lane_owner_e       cur;
    lane_owner_e       owner [2];
    logic              slot_n;
    logic              started;
    logic [1:0]        ended;
    logic              sop_err;
    logic              eop_err;
    logic [KEEP_W-1:0] keep_m;
    lane_cmd_t         cmd_n [2];

    assign sop      = s_tuser[SOP_LSB +: 2];
    assign sop_ptr0 = s_tuser[SOP_PTR_LSB +: 2];
    assign eop      = s_tuser[EOP_LSB +: 2];
    assign eop_ptr0 = s_tuser[EOP_PTR_LSB +: 4];
    assign eop_ptr1 = s_tuser[EOP_PTR_LSB + 4 +: 4];

    // Accept is the slave ready seen by the top level
    assign fire = s_tvalid && accept;

    // Start goes to lane 0 when its pointer is zero
    assign start_at[0] = sop[0] && (sop_ptr0 == 2'b00);
    assign start_at[1] = sop[0] && (sop_ptr0 != 2'b00);

    // A second end can only sit in lane 1, behind a first end in lane 0
    assign end_at[0]  = eop[0] && !eop_ptr0[3];
    assign end_at[1]  = eop[1] || (eop[0] && eop_ptr0[3]);
    assign end_ptr[0] = eop_ptr0[2:0];
    assign end_ptr[1] = eop[1] ? eop_ptr1[2:0] : eop_ptr0[2:0];

    // Walk the lanes in order, start markers before end markers
    always_comb begin
        cur     = carry_q;
        slot_n  = last_slot_q;
        started = 1'b0;
        ended   = 2'b00;
        keep_m  = s_tkeep;
        // The order queue takes a single start per beat
        sop_err = sop[1];
        eop_err = eop[1] && !end_at[0];
        for (int l = 0; l < 2; l++) begin
            if (start_at[l]) begin
                if (cur != LANE_FREE) begin
                    sop_err = 1'b1;
                end else begin
                    started = 1'b1;
                    slot_n  = !last_slot_q;
                    cur     = slot_n ? LANE_SLOT1 : LANE_SLOT0;
                end
            end
            owner[l] = cur;
            if (end_at[l]) begin
                if (cur == LANE_FREE) begin
                    eop_err = 1'b1;
                end else begin
                    ended[cur == LANE_SLOT1] = 1'b1;
                    // Keep only dwords at or below the end pointer
                    keep_m[l*LANE_KEEP_W +: LANE_KEEP_W] =
                        s_tkeep[l*LANE_KEEP_W +: LANE_KEEP_W] &
                        ({LANE_KEEP_W{1'b1}} >> (LANE_KEEP_W - 1 - end_ptr[l]));
                    cur = LANE_FREE;
                end
            end
        end
    end

    always_comb begin
        for (int s = 0; s < 2; s++) begin
            cmd_n[s].lane_mask[0] = (owner[0] == (s == 0 ? LANE_SLOT0 : LANE_SLOT1));
            cmd_n[s].lane_mask[1] = (owner[1] == (s == 0 ? LANE_SLOT0 : LANE_SLOT1));
            cmd_n[s].data_lo      = s_tdata[LANE_W-1:0];
            cmd_n[s].data_hi      = s_tdata[DATA_W-1:LANE_W];
            cmd_n[s].keep_lo      = keep_m[LANE_KEEP_W-1:0];
            cmd_n[s].keep_hi      = keep_m[KEEP_W-1:LANE_KEEP_W];
            cmd_n[s].end_flag     = ended[s];
        end
    end

    always_ff @(posedge ACLK) begin
        if (!ARESETN) begin
            carry_q     <= LANE_FREE;
            last_slot_q <= 1'b1;
            cmd_valid   <= 1'b0;
            start_push  <= 1'b0;
            start_slot  <= 1'b0;
            err         <= '0;
        end else begin
            cmd_valid  <= 1'b0;
            start_push <= 1'b0;
            if (fire) begin
                err.illegal_sop <= err.illegal_sop | sop_err;
                err.illegal_eop <= err.illegal_eop | eop_err;
                // A faulty beat is dropped and leaves the lane state alone
                if (!sop_err && !eop_err) begin
                    carry_q     <= cur;
                    last_slot_q <= slot_n;
                    cmd_valid   <= 1'b1;
                    start_push  <= started;
                    start_slot  <= slot_n;
                end
            end
        end
    end

    always_ff @(posedge ACLK) begin
        if (fire) begin
            cmd0 <= cmd_n[0];
            cmd1 <= cmd_n[1];
        end
    end

endmodule

`default_nettype wire

// File: straddle_slot_packer.sv
`default_nettype none

module straddle_slot_packer import straddle_pkg::*; (
    input  wire              ACLK,
    input  wire              ARESETN,
    input  wire lane_cmd_t   cmd,
    input  wire              cmd_valid,
    input  wire              pop,
    output beat_t            beat,
    output logic             beat_valid,
    output logic [FIFO_AW:0] free_count
);

    beat_t                  mem [FIFO_DEPTH];
    logic [FIFO_AW:0]       wr_ptr;
    logic [FIFO_AW:0]       rd_ptr;
    logic [FIFO_AW:0]       used;
    logic [FIFO_AW-1:0]     wr_idx1;

    // Low half waiting for its partner lane
    logic                   pend_q;
    logic [LANE_W-1:0]      pend_data_q;
    logic [LANE_KEEP_W-1:0] pend_keep_q;

    logic                   have;
    logic [LANE_W-1:0]      half_data;
    logic [LANE_KEEP_W-1:0] half_keep;
    logic [LANE_W-1:0]      lane_data;
    logic [LANE_KEEP_W-1:0] lane_keep;
    logic [1:0]             push_cnt;
    beat_t                  push_beat [2];

    always_comb begin
        have         = pend_q;
        half_data    = pend_data_q;
        half_keep    = pend_keep_q;
        lane_data    = '0;
        lane_keep    = '0;
        push_cnt     = 2'd0;
        push_beat[0] = '0;
        push_beat[1] = '0;
        if (cmd_valid) begin
            for (int l = 0; l < 2; l++) begin
                if (cmd.lane_mask[l]) begin
                    lane_data = (l == 1) ? cmd.data_hi : cmd.data_lo;
                    lane_keep = (l == 1) ? cmd.keep_hi : cmd.keep_lo;
                    if (have) begin
                        push_beat[push_cnt[0]].data = {lane_data, half_data};
                        push_beat[push_cnt[0]].keep = {lane_keep, half_keep};
                        // Last only if no later lane of this packet follows
                        push_beat[push_cnt[0]].last =
                            cmd.end_flag && ((l == 1) || !cmd.lane_mask[1]);
                        push_cnt = push_cnt + 2'd1;
                        have     = 1'b0;
                    end else begin
                        have      = 1'b1;
                        half_data = lane_data;
                        half_keep = lane_keep;
                    end
                end
            end
            // Packet closes on a lone half, upper half left empty
            if (cmd.end_flag && have) begin
                push_beat[push_cnt[0]].data = {{LANE_W{1'b0}}, half_data};
                push_beat[push_cnt[0]].keep = {{LANE_KEEP_W{1'b0}}, half_keep};
                push_beat[push_cnt[0]].last = 1'b1;
                push_cnt = push_cnt + 2'd1;
                have     = 1'b0;
            end
        end
    end

    assign wr_idx1    = wr_ptr[FIFO_AW-1:0] + 1'b1;
    assign used       = wr_ptr - rd_ptr;
    assign free_count = (FIFO_AW + 1)'(FIFO_DEPTH) - used;
    assign beat_valid = (wr_ptr != rd_ptr);
    assign beat       = mem[rd_ptr[FIFO_AW-1:0]];

    always_ff @(posedge ACLK) begin
        if (!ARESETN) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            pend_q <= 1'b0;
        end else begin
            wr_ptr <= wr_ptr + push_cnt;
            pend_q <= have;
            if (pop && beat_valid) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge ACLK) begin
        pend_data_q <= half_data;
        pend_keep_q <= half_keep;
        if (push_cnt != 2'd0) begin
            mem[wr_ptr[FIFO_AW-1:0]] <= push_beat[0];
        end
        if (push_cnt == 2'd2) begin
            mem[wr_idx1] <= push_beat[1];
        end
    end

endmodule

`default_nettype wire

// File: straddle_output_arbiter.sv
`default_nettype none

module straddle_output_arbiter import straddle_pkg::*; (
    input  wire               ACLK,
    input  wire               ARESETN,
    input  wire               start_push,
    input  wire               start_slot,
    input  wire beat_t        beat0,
    input  wire               beat_valid0,
    input  wire beat_t        beat1,
    input  wire               beat_valid1,
    input  wire               m_tready,
    output logic [DATA_W-1:0] m_tdata,
    output logic [KEEP_W-1:0] m_tkeep,
    output logic              m_tlast,
    output logic              m_tvalid,
    output logic              pop0,
    output logic              pop1
);

    // Slot numbers in the order the packets started
    logic              order_q [ORDER_DEPTH];
    logic [ORDER_AW:0] q_wr;
    logic [ORDER_AW:0] q_rd;
    logic              q_empty;
    logic              head_slot;
    logic              fire;
    beat_t             head_beat;

    assign q_empty   = (q_wr == q_rd);
    assign head_slot = order_q[q_rd[ORDER_AW-1:0]];
    assign head_beat = head_slot ? beat1 : beat0;

    // Head packet may be queued before its first beat reaches the FIFO
    assign m_tvalid = !q_empty && (head_slot ? beat_valid1 : beat_valid0);
    assign m_tdata  = head_beat.data;
    assign m_tkeep  = head_beat.keep;
    assign m_tlast  = head_beat.last;

    assign fire = m_tvalid && m_tready;
    assign pop0 = fire && !head_slot;
    assign pop1 = fire && head_slot;

    always_ff @(posedge ACLK) begin
        if (!ARESETN) begin
            q_wr <= '0;
            q_rd <= '0;
        end else begin
            if (start_push) begin
                q_wr <= q_wr + 1'b1;
            end
            // Move on to the next packet once its last beat has gone out
            if (fire && m_tlast) begin
                q_rd <= q_rd + 1'b1;
            end
        end
    end

    always_ff @(posedge ACLK) begin
        if (start_push) begin
            order_q[q_wr[ORDER_AW-1:0]] <= start_slot;
        end
    end

endmodule

`default_nettype wire

// File: straddle_convertor.sv
`default_nettype none

module straddle_convertor import straddle_pkg::*; (
    input  wire               ACLK,
    input  wire               ARESETN,
    input  wire [USER_W-1:0]  s_tuser,
    input  wire [DATA_W-1:0]  s_tdata,
    input  wire [KEEP_W-1:0]  s_tkeep,
    // Packet bounds come from the sideband, so tlast is not looked at
    input  wire               s_tlast,
    input  wire               s_tvalid,
    output logic              s_tready,
    output logic [DATA_W-1:0] m_tdata,
    output logic [KEEP_W-1:0] m_tkeep,
    output logic              m_tlast,
    output logic              m_tvalid,
    input  wire               m_tready,
    output err_flags_t        err
);

    lane_cmd_t        cmd0;
    lane_cmd_t        cmd1;
    logic             cmd_valid;
    logic             start_push;
    logic             start_slot;
    beat_t            beat0;
    beat_t            beat1;
    logic             beat_valid0;
    logic             beat_valid1;
    logic [FIFO_AW:0] free_count0;
    logic [FIFO_AW:0] free_count1;
    logic             pop0;
    logic             pop1;

    // Room for the command in flight plus two pushes per slot from a new beat
    assign s_tready = (free_count0 >= READY_MARGIN) && (free_count1 >= READY_MARGIN);

    straddle_lane_decoder i_lane_decoder (
        .ACLK       (ACLK),
        .ARESETN    (ARESETN),
        .s_tuser    (s_tuser),
        .s_tdata    (s_tdata),
        .s_tkeep    (s_tkeep),
        .s_tvalid   (s_tvalid),
        .accept     (s_tready),
        .cmd0       (cmd0),
        .cmd1       (cmd1),
        .cmd_valid  (cmd_valid),
        .start_push (start_push),
        .start_slot (start_slot),
        .err        (err)
    );

    straddle_slot_packer i_slot_packer0 (
        .ACLK       (ACLK),
        .ARESETN    (ARESETN),
        .cmd        (cmd0),
        .cmd_valid  (cmd_valid),
        .pop        (pop0),
        .beat       (beat0),
        .beat_valid (beat_valid0),
        .free_count (free_count0)
    );

    straddle_slot_packer i_slot_packer1 (
        .ACLK       (ACLK),
        .ARESETN    (ARESETN),
        .cmd        (cmd1),
        .cmd_valid  (cmd_valid),
        .pop        (pop1),
        .beat       (beat1),
        .beat_valid (beat_valid1),
        .free_count (free_count1)
    );

    straddle_output_arbiter i_output_arbiter (
        .ACLK        (ACLK),
        .ARESETN     (ARESETN),
        .start_push  (start_push),
        .start_slot  (start_slot),
        .beat0       (beat0),
        .beat_valid0 (beat_valid0),
        .beat1       (beat1),
        .beat_valid1 (beat_valid1),
        .m_tready    (m_tready),
        .m_tdata     (m_tdata),
        .m_tkeep     (m_tkeep),
        .m_tlast     (m_tlast),
        .m_tvalid    (m_tvalid),
        .pop0        (pop0),
        .pop1        (pop1)
    );

endmodule

`default_nettype wire

// File: straddle_convertor_assertions.sv
`default_nettype none

module straddle_convertor_assertions import straddle_pkg::*; (
    input wire               ACLK,
    input wire               ARESETN,
    input wire [DATA_W-1:0]  m_tdata,
    input wire [KEEP_W-1:0]  m_tkeep,
    input wire               m_tlast,
    input wire               m_tvalid,
    input wire               m_tready,
    input wire err_flags_t   err,
    input wire [FIFO_AW:0]   free_count0,
    input wire [FIFO_AW:0]   free_count1
);

    // Output handshake
    assert property (@(posedge ACLK) disable iff (!ARESETN)
        m_tvalid && !m_tready |=> m_tvalid)
        else $error("m_tvalid dropped before the beat was taken");

    assert property (@(posedge ACLK) disable iff (!ARESETN)
        m_tvalid && !m_tready |=> $stable(m_tdata) && $stable(m_tkeep) && $stable(m_tlast))
        else $error("output beat changed while stalled");

    // Error flags are sticky
    assert property (@(posedge ACLK) disable iff (!ARESETN)
        err.illegal_sop |=> err.illegal_sop)
        else $error("illegal_sop cleared without reset");

    assert property (@(posedge ACLK) disable iff (!ARESETN)
        err.illegal_eop |=> err.illegal_eop)
        else $error("illegal_eop cleared without reset");

    // The ready margin keeps both slot FIFOs from overrunning
    assert property (@(posedge ACLK) disable iff (!ARESETN)
        (free_count0 <= FIFO_DEPTH) && (free_count1 <= FIFO_DEPTH))
        else $error("slot FIFO overran its depth");

endmodule

`default_nettype wire

// File: tb_straddle_convertor.sv
`default_nettype none

module tb_straddle_convertor import straddle_pkg::*; ();

    localparam int STIM_MAX       = 64;
    localparam int CYCLES_PER_REC = 40;

    // One line of the stim file with one hex digit per field except tags and keep
    typedef struct packed {
        logic [3:0]  kind;
        logic [3:0]  sop;
        logic [3:0]  sop_ptr;
        logic [3:0]  eop;
        logic [3:0]  eop_ptr0;
        logic [3:0]  eop_ptr1;
        logic [15:0] tag_lo;
        logic [15:0] tag_hi;
        logic [15:0] keep;
        logic [3:0]  gap;
        logic [3:0]  rep;
        logic [3:0]  flag;
    } stim_rec_t;

    logic              ACLK;
    logic              ARESETN;
    logic [USER_W-1:0] s_tuser;
    logic [DATA_W-1:0] s_tdata;
    logic [KEEP_W-1:0] s_tkeep;
    logic              s_tlast;
    logic              s_tvalid;
    logic              s_tready;
    logic [DATA_W-1:0] m_tdata;
    logic [KEEP_W-1:0] m_tkeep;
    logic              m_tlast;
    logic              m_tvalid;
    logic              m_tready;
    err_flags_t        err;

    logic [$bits(stim_rec_t)-1:0] stim_mem [STIM_MAX];
    stim_rec_t  rec;
    beat_t      exp_q [$];
    beat_t      mon_beat;
    err_flags_t exp_err;
    logic       hold_out;
    int         rec_count;
    int         exp_total;
    int         recv_count;
    int         fail_count;
    int         test_fails;
    int         test_count;
    int         cycle_count;
    int         cycle_limit;

    straddle_convertor i_straddle_convertor (
        .ACLK     (ACLK),
        .ARESETN  (ARESETN),
        .s_tuser  (s_tuser),
        .s_tdata  (s_tdata),
        .s_tkeep  (s_tkeep),
        .s_tlast  (s_tlast),
        .s_tvalid (s_tvalid),
        .s_tready (s_tready),
        .m_tdata  (m_tdata),
        .m_tkeep  (m_tkeep),
        .m_tlast  (m_tlast),
        .m_tvalid (m_tvalid),
        .m_tready (m_tready),
        .err      (err)
    );

    bind straddle_convertor straddle_convertor_assertions i_assertions (
        .ACLK        (ACLK),
        .ARESETN     (ARESETN),
        .m_tdata     (m_tdata),
        .m_tkeep     (m_tkeep),
        .m_tlast     (m_tlast),
        .m_tvalid    (m_tvalid),
        .m_tready    (m_tready),
        .err         (err),
        .free_count0 (free_count0),
        .free_count1 (free_count1)
    );

    // Every dword carries its lane tag and its position
    function automatic logic [LANE_W-1:0] lane_fill(input logic [15:0] tag);
        logic [LANE_W-1:0] v;
        for (int d = 0; d < LANE_KEEP_W; d++) begin
            v[d*32 +: 32] = {tag, 8'h5a, 8'(d)};
        end
        return v;
    endfunction

    // Copy k of a record steps both tags by two
    function automatic beat_t expected_beat(input stim_rec_t r, input int k);
        beat_t b;
        b.data = {lane_fill(r.tag_hi + 16'(2 * k)), lane_fill(r.tag_lo + 16'(2 * k))};
        b.keep = r.keep;
        b.last = r.flag[0];
        return b;
    endfunction

    task automatic check_beat(input beat_t got, input beat_t exp);
        logic [DATA_W-1:0] mask;
        for (int d = 0; d < KEEP_W; d++) begin
            mask[d*32 +: 32] = {32{exp.keep[d]}};
        end
        if (got.keep !== exp.keep || got.last !== exp.last ||
            ((got.data ^ exp.data) & mask) !== '0) begin
            fail_count++;
            $display("FAILED at %0t: output beat %0d got keep %h last %b data %h, expected %h %b %h",
                     $time, recv_count, got.keep, got.last, got.data[31:0],
                     exp.keep, exp.last, exp.data[31:0]);
        end
    endtask

    task automatic check_err(input err_flags_t got, input err_flags_t exp);
        if (got !== exp) begin
            fail_count++;
            $display("FAILED at %0t: err is sop %b eop %b, expected sop %b eop %b",
                     $time, got.illegal_sop, got.illegal_eop, exp.illegal_sop, exp.illegal_eop);
        end
    endtask

    task automatic drive_record(input stim_rec_t r);
        logic [USER_W-1:0] user;
        user = '0;
        user[SOP_LSB +: 2]         = r.sop[1:0];
        user[SOP_PTR_LSB +: 2]     = r.sop_ptr[1:0];
        user[EOP_LSB +: 2]         = r.eop[1:0];
        user[EOP_PTR_LSB +: 4]     = r.eop_ptr0;
        user[EOP_PTR_LSB + 4 +: 4] = r.eop_ptr1;
        for (int k = 0; k <= r.rep; k++) begin
            s_tvalid <= 1'b1;
            s_tuser  <= user;
            s_tdata  <= {lane_fill(r.tag_hi + 16'(2 * k)), lane_fill(r.tag_lo + 16'(2 * k))};
            s_tkeep  <= r.keep;
            s_tlast  <= |r.eop[1:0];
            @(negedge ACLK);
            while (!s_tready) begin
                // Back-pressure reached the input, so let the output drain
                hold_out = 1'b0;
                @(negedge ACLK);
            end
            @(posedge ACLK);
        end
        if (r.gap != 0) begin
            s_tvalid <= 1'b0;
            repeat (r.gap) @(posedge ACLK);
        end
    endtask

    task automatic finish_test();
        s_tvalid <= 1'b0;
        @(negedge ACLK);
        if (hold_out) begin
            fail_count++;
            $display("s_tready never fell while the output was held at %0t", $time);
            hold_out = 1'b0;
        end
        while (recv_count < exp_total) begin
            @(negedge ACLK);
        end
        check_err(err, exp_err);
        test_count++;
        $display("test %0d finished with %0d output beats so far, %0s",
                 test_count, recv_count, (fail_count == test_fails) ? "ok" : "with errors");
        test_fails = fail_count;
        @(posedge ACLK);
    endtask

    initial begin
        ACLK = 1'b0;
        forever #10 ACLK = ~ACLK;
    end

    // Output stalls in about 30 percent of cycles unless held
    initial begin
        void'($urandom(32'hdfaf));
        forever begin
            @(posedge ACLK);
            if (hold_out) begin
                m_tready <= 1'b0;
            end else begin
                m_tready <= ($urandom % 100) >= 30;
            end
        end
    end

    always @(negedge ACLK) begin
        if (ARESETN && m_tvalid && m_tready) begin
            mon_beat.data = m_tdata;
            mon_beat.keep = m_tkeep;
            mon_beat.last = m_tlast;
            if (exp_q.size() == 0) begin
                fail_count++;
                $display("unexpected extra output beat at %0t", $time);
            end else begin
                check_beat(mon_beat, exp_q.pop_front());
            end
            recv_count++;
        end
    end

    initial begin
        cycle_count = 0;
        @(posedge ACLK);
        while (cycle_count < cycle_limit) begin
            @(posedge ACLK);
            cycle_count++;
        end
        $display("timeout after %0d cycles, only %0d of %0d expected output beats arrived",
                 cycle_count, recv_count, exp_total);
        $display("sim failed");
        $finish;
    end

    initial begin
        ARESETN    = 1'b0;
        s_tuser    = '0;
        s_tdata    = '0;
        s_tkeep    = '0;
        s_tlast    = 1'b0;
        s_tvalid   = 1'b0;
        m_tready   = 1'b0;
        hold_out   = 1'b0;
        exp_err    = '0;
        exp_total  = 0;
        recv_count = 0;
        fail_count = 0;
        test_fails = 0;
        test_count = 0;
        $readmemh("straddle_stim.mem", stim_mem);
        rec_count = -1;
        for (int i = STIM_MAX - 1; i >= 0; i--) begin
            rec = stim_mem[i];
            if (rec.kind === 4'hf) begin
                rec_count = i;
            end
        end
        if (rec_count < 0) begin
            fail_count++;
            $display("stim file is missing or has no end record");
            rec_count = 0;
        end
        for (int i = 0; i < rec_count; i++) begin
            rec = stim_mem[i];
            if (rec.kind == 4'h2) begin
                for (int k = 0; k <= rec.rep; k++) begin
                    exp_q.push_back(expected_beat(rec, k));
                end
            end
        end
        cycle_limit = (rec_count + 1) * CYCLES_PER_REC;
        repeat (3) @(posedge ACLK);
        ARESETN <= 1'b1;
        for (int i = 0; i < rec_count; i++) begin
            rec = stim_mem[i];
            case (rec.kind)
                4'h1: drive_record(rec);
                4'h2: exp_total += rec.rep + 1;
                4'h3: exp_err = rec.flag[1:0];
                4'h4: finish_test();
                4'h5: begin
                    @(negedge ACLK);
                    hold_out = 1'b1;
                    @(posedge ACLK);
                end
                default: begin
                    fail_count++;
                    $display("stim record %0d has unknown kind %h", i, rec.kind);
                end
            endcase
        end
        $display("tests %0d, output beats checked %0d, errors %0d",
                 test_count, recv_count, fail_count);
        if (fail_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: straddle_stim.mem
// kind sop sop_ptr eop eop_ptr0 eop_ptr1 tag_lo tag_hi keep gap rep flag
// kind 1 input beat, 2 expected beat, 3 expected err, 4 end of test, 5 hold output, f end
// Unstraddled packets from lane 0
1_1_0_0_0_0_0101_0102_ffff_0_0_0
1_0_0_1_d_0_0103_0104_ffff_0_0_0
1_1_0_1_3_0_0201_0000_00ff_2_0_0
1_1_0_1_f_0_0301_0302_ffff_0_0_0
2_0_0_0_0_0_0101_0102_ffff_0_0_0
2_0_0_0_0_0_0103_0104_3fff_0_0_1
2_0_0_0_0_0_0201_0000_000f_0_0_1
2_0_0_0_0_0_0301_0302_ffff_0_0_1
3_0_0_0_0_0_0000_0000_0000_0_0_0
4_0_0_0_0_0_0000_0000_0000_0_0_0
// End in lane 0 and start in lane 1 of the same beat
1_1_0_0_0_0_0401_0402_ffff_0_0_0
1_1_2_1_6_0_0403_0501_ffff_0_0_0
1_0_0_1_a_0_0502_0503_ffff_0_0_0
2_0_0_0_0_0_0401_0402_ffff_0_0_0
2_0_0_0_0_0_0403_0000_007f_0_0_1
2_0_0_0_0_0_0501_0502_ffff_0_0_0
2_0_0_0_0_0_0503_0000_0007_0_0_1
3_0_0_0_0_0_0000_0000_0000_0_0_0
4_0_0_0_0_0_0000_0000_0000_0_0_0
// Packet starting in lane 1 is realigned
1_1_2_0_0_0_0000_0601_ff00_0_0_0
1_0_0_0_0_0_0602_0603_ffff_0_0_0
1_0_0_1_7_0_0604_0000_00ff_0_0_0
2_0_0_0_0_0_0601_0602_ffff_0_0_0
2_0_0_0_0_0_0603_0604_ffff_0_0_1
3_0_0_0_0_0_0000_0000_0000_0_0_0
4_0_0_0_0_0_0000_0000_0000_0_0_0
// Long packet against a held output
5_0_0_0_0_0_0000_0000_0000_0_0_0
1_1_0_0_0_0_0701_0702_ffff_0_0_0
1_0_0_0_0_0_0703_0704_ffff_0_c_0
1_0_0_1_b_0_071d_071e_ffff_0_0_0
2_0_0_0_0_0_0701_0702_ffff_0_0_0
2_0_0_0_0_0_0703_0704_ffff_0_c_0
2_0_0_0_0_0_071d_071e_0fff_0_0_1
3_0_0_0_0_0_0000_0000_0000_0_0_0
4_0_0_0_0_0_0000_0000_0000_0_0_0
// Illegal start inside a packet
1_1_0_0_0_0_0801_0802_ffff_0_0_0
1_1_0_0_0_0_0f01_0f02_ffff_0_0_0
1_0_0_1_f_0_0803_0804_ffff_0_0_0
2_0_0_0_0_0_0801_0802_ffff_0_0_0
2_0_0_0_0_0_0803_0804_ffff_0_0_1
3_0_0_0_0_0_0000_0000_0000_0_0_2
4_0_0_0_0_0_0000_0000_0000_0_0_0
// End on a free lane
1_0_0_1_0_0_0e01_0000_00ff_0_0_0
1_1_0_1_9_0_0901_0902_ffff_0_0_0
2_0_0_0_0_0_0901_0902_03ff_0_0_1
3_0_0_0_0_0_0000_0000_0000_0_0_3
4_0_0_0_0_0_0000_0000_0000_0_0_0
f_0_0_0_0_0_0000_0000_0000_0_0_0

// File: flist.f
straddle_pkg.sv
straddle_lane_decoder.sv
straddle_slot_packer.sv
straddle_output_arbiter.sv
straddle_convertor.sv
straddle_convertor_assertions.sv
tb_straddle_convertor.sv
